// ==== src/ao_periph_pkg.sv ====
// Always-on peripheral subsystem package
// Bus structs, decode enums and register offsets

`default_nettype none

package ao_periph_pkg;

  localparam int unsigned NUM_PERIPH    = 3;
  localparam int unsigned NUM_FAST_INTR = 15;
  localparam int unsigned NUM_GPIO      = 8;

  // OBI port, full 32-bit words only
  typedef struct packed {
    logic        req;
    logic        we;
    logic [31:0] addr;
    logic [31:0] wdata;
  } obi_req_t;

  typedef struct packed {
    logic        gnt;
    logic        rvalid;
    logic [31:0] rdata;
  } obi_resp_t;

  // Internal register bus
  typedef struct packed {
    logic        valid;
    logic        write;
    logic [31:0] addr;
    logic [31:0] wdata;
  } reg_req_t;

  typedef struct packed {
    logic        ready;
    logic [31:0] rdata;
  } reg_rsp_t;

  // Taken from address bits 15:12
  typedef enum logic [1:0] {
    SOC_CTRL_IDX  = 2'd0,
    FAST_INTR_IDX = 2'd1,
    GPIO_IDX      = 2'd2,
    NONE_IDX      = 2'd3
  } periph_idx_e;

  typedef enum logic [1:0] {
    BR_IDLE    = 2'd0,
    BR_ACCESS  = 2'd1,
    BR_RESPOND = 2'd2
  } bridge_state_e;

  // Byte offsets, decoded on bits 4:2
  localparam logic [4:0] SOC_CTRL_EXIT_VALID = 5'h00;
  localparam logic [4:0] SOC_CTRL_EXIT_VALUE = 5'h04;
  localparam logic [4:0] SOC_CTRL_BOOT_SEL   = 5'h08;
  localparam logic [4:0] SOC_CTRL_SCRATCH    = 5'h0C;

  localparam logic [4:0] FAST_INTR_PENDING = 5'h00;
  localparam logic [4:0] FAST_INTR_ENABLE  = 5'h04;

  localparam logic [4:0] GPIO_IN          = 5'h00;
  localparam logic [4:0] GPIO_OUT         = 5'h04;
  localparam logic [4:0] GPIO_OE          = 5'h08;
  localparam logic [4:0] GPIO_INTR_EN     = 5'h0C;
  localparam logic [4:0] GPIO_INTR_STATUS = 5'h10;

endpackage

`default_nettype wire

// ==== src/obi_to_reg.sv ====
// OBI to register bus bridge
// One granted access becomes one register transfer, answered by an rvalid pulse

`timescale 1ns/100ps
`default_nettype none

module obi_to_reg (
  input  logic                     clk_i,
  input  logic                     reset_i,
  input  ao_periph_pkg::obi_req_t  obi_req_i,
  output ao_periph_pkg::obi_resp_t obi_resp_o,
  output ao_periph_pkg::reg_req_t  reg_req_o,
  input  ao_periph_pkg::reg_rsp_t  reg_rsp_i
);
  import ao_periph_pkg::*;

  bridge_state_e state_q;
  bridge_state_e state_d;
  logic          grant;
  logic          we_q;
  logic [31:0]   addr_q;
  logic [31:0]   wdata_q;
  logic [31:0]   rdata_q;

  // Only one access in flight
  assign grant = obi_req_i.req && (state_q == BR_IDLE);

  always_comb begin
    state_d = state_q;
    case (state_q)
      BR_IDLE: begin
        if (grant) begin
          state_d = BR_ACCESS;
        end
      end
      BR_ACCESS: begin
        if (reg_rsp_i.ready) begin
          state_d = BR_RESPOND;
        end
      end
      default: state_d = BR_IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q <= BR_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (grant) begin
      we_q    <= obi_req_i.we;
      addr_q  <= obi_req_i.addr;
      wdata_q <= obi_req_i.wdata;
    end
    // Writes return zero
    if (state_q == BR_ACCESS && reg_rsp_i.ready) begin
      rdata_q <= we_q ? '0 : reg_rsp_i.rdata;
    end
  end

  assign reg_req_o.valid = (state_q == BR_ACCESS);
  assign reg_req_o.write = we_q;
  assign reg_req_o.addr  = addr_q;
  assign reg_req_o.wdata = wdata_q;

  assign obi_resp_o.gnt    = grant;
  assign obi_resp_o.rvalid = (state_q == BR_RESPOND);
  assign obi_resp_o.rdata  = rdata_q;

  a_gnt_to_rvalid : assert property (@(posedge clk_i) disable iff (reset_i)
    obi_resp_o.gnt |=> reg_rsp_i.ready ##1 obi_resp_o.rvalid);

  a_rvalid_pulse : assert property (@(posedge clk_i) disable iff (reset_i)
    obi_resp_o.rvalid |=> !obi_resp_o.rvalid);

endmodule

`default_nettype wire

// ==== src/reg_demux.sv ====
// Register bus demultiplexer
// Decodes bits 15:12 and routes one transfer to a peripheral or the zero path

`timescale 1ns/100ps
`default_nettype none

module reg_demux (
  input  ao_periph_pkg::reg_req_t                               reg_req_i,
  output ao_periph_pkg::reg_rsp_t                               reg_rsp_o,
  output ao_periph_pkg::reg_req_t [ao_periph_pkg::NUM_PERIPH-1:0] periph_req_o,
  input  ao_periph_pkg::reg_rsp_t [ao_periph_pkg::NUM_PERIPH-1:0] periph_rsp_i,
  input  logic                                                  clk_i,
  input  logic                                                  reset_i
);
  import ao_periph_pkg::*;

  periph_idx_e           idx;
  logic [NUM_PERIPH-1:0] sel_valid;

  always_comb begin
    if (reg_req_i.addr[15:12] < 4'(NUM_PERIPH)) begin
      idx = periph_idx_e'(reg_req_i.addr[13:12]);
    end else begin
      idx = NONE_IDX;
    end
  end

  // Same transfer to all, valid to the selected one only
  always_comb begin
    for (int i = 0; i < NUM_PERIPH; i++) begin
      sel_valid[i]          = reg_req_i.valid && (idx == periph_idx_e'(i));
      periph_req_o[i]       = reg_req_i;
      periph_req_o[i].valid = sel_valid[i];
    end
  end

  always_comb begin
    // Unmapped answers at once with zero data
    reg_rsp_o.ready = reg_req_i.valid;
    reg_rsp_o.rdata = '0;
    case (idx)
      SOC_CTRL_IDX:  reg_rsp_o = periph_rsp_i[SOC_CTRL_IDX];
      FAST_INTR_IDX: reg_rsp_o = periph_rsp_i[FAST_INTR_IDX];
      GPIO_IDX:      reg_rsp_o = periph_rsp_i[GPIO_IDX];
      default:       reg_rsp_o.rdata = '0;
    endcase
  end

  a_one_select : assert property (@(posedge clk_i) disable iff (reset_i)
    $onehot0(sel_valid));

endmodule

`default_nettype wire

// ==== src/soc_ctrl.sv ====
// SoC control registers
// Boot select, simulation exit flag and value, scratch word

`timescale 1ns/100ps
`default_nettype none

module soc_ctrl (
  input  logic                    clk_i,
  input  logic                    reset_i,
  input  ao_periph_pkg::reg_req_t reg_req_i,
  output ao_periph_pkg::reg_rsp_t reg_rsp_o,
  input  logic                    boot_select_i,
  output logic                    exit_valid_o,
  output logic [31:0]             exit_value_o
);
  import ao_periph_pkg::*;

  logic        exit_valid_q;
  logic [31:0] exit_value_q;
  logic [31:0] scratch_q;
  logic        wr_en;
  logic [4:0]  offset;

  assign offset = {reg_req_i.addr[4:2], 2'b00};
  assign wr_en  = reg_req_i.valid && reg_req_i.write;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      exit_valid_q <= 1'b0;
      exit_value_q <= '0;
      scratch_q    <= '0;
    end else if (wr_en) begin
      case (offset)
        // Sticky until reset
        SOC_CTRL_EXIT_VALID: exit_valid_q <= exit_valid_q | reg_req_i.wdata[0];
        SOC_CTRL_EXIT_VALUE: exit_value_q <= reg_req_i.wdata;
        SOC_CTRL_SCRATCH:    scratch_q    <= reg_req_i.wdata;
        default: ;
      endcase
    end
  end

  always_comb begin
    reg_rsp_o.ready = reg_req_i.valid;
    case (offset)
      SOC_CTRL_EXIT_VALID: reg_rsp_o.rdata = {31'b0, exit_valid_q};
      SOC_CTRL_EXIT_VALUE: reg_rsp_o.rdata = exit_value_q;
      SOC_CTRL_BOOT_SEL:   reg_rsp_o.rdata = {31'b0, boot_select_i};
      SOC_CTRL_SCRATCH:    reg_rsp_o.rdata = scratch_q;
      default:             reg_rsp_o.rdata = '0;
    endcase
  end

  assign exit_valid_o = exit_valid_q;
  assign exit_value_o = exit_value_q;

  a_exit_sticky : assert property (@(posedge clk_i) disable iff (reset_i)
    exit_valid_o |=> exit_valid_o);

endmodule

`default_nettype wire

// ==== src/fast_intr_ctrl.sv ====
// Fast interrupt controller
// Pending bits with write-one-to-clear, masked by enable

`timescale 1ns/100ps
`default_nettype none

module fast_intr_ctrl (
  input  logic                                    clk_i,
  input  logic                                    reset_i,
  input  ao_periph_pkg::reg_req_t                 reg_req_i,
  output ao_periph_pkg::reg_rsp_t                 reg_rsp_o,
  input  logic [ao_periph_pkg::NUM_FAST_INTR-1:0] fast_intr_i,
  output logic [ao_periph_pkg::NUM_FAST_INTR-1:0] fast_intr_o
);
  import ao_periph_pkg::*;

  logic [NUM_FAST_INTR-1:0] pending_q;
  logic [NUM_FAST_INTR-1:0] enable_q;
  logic [NUM_FAST_INTR-1:0] pend_clr;
  logic                     wr_en;
  logic [4:0]               offset;

  assign offset   = {reg_req_i.addr[4:2], 2'b00};
  assign wr_en    = reg_req_i.valid && reg_req_i.write;
  assign pend_clr = (wr_en && offset == FAST_INTR_PENDING) ?
                    reg_req_i.wdata[NUM_FAST_INTR-1:0] : '0;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      pending_q <= '0;
      enable_q  <= '0;
    end else begin
      // A live input wins over a clear
      pending_q <= (pending_q & ~pend_clr) | fast_intr_i;
      if (wr_en && offset == FAST_INTR_ENABLE) begin
        enable_q <= reg_req_i.wdata[NUM_FAST_INTR-1:0];
      end
    end
  end

  always_comb begin
    reg_rsp_o.ready = reg_req_i.valid;
    case (offset)
      FAST_INTR_PENDING: reg_rsp_o.rdata = 32'(pending_q);
      FAST_INTR_ENABLE:  reg_rsp_o.rdata = 32'(enable_q);
      default:           reg_rsp_o.rdata = '0;
    endcase
  end

  assign fast_intr_o = pending_q & enable_q;

  a_pend_capture : assert property (@(posedge clk_i) disable iff (reset_i)
    (fast_intr_i != '0) |=> ((pending_q & $past(fast_intr_i)) == $past(fast_intr_i)));

endmodule

`default_nettype wire

// ==== src/gpio_ao.sv ====
// Always-on GPIO
// Output and enable registers, synchronised inputs, rising-edge interrupts

`timescale 1ns/100ps
`default_nettype none

module gpio_ao (
  input  logic                               clk_i,
  input  logic                               reset_i,
  input  ao_periph_pkg::reg_req_t            reg_req_i,
  output ao_periph_pkg::reg_rsp_t            reg_rsp_o,
  input  logic [ao_periph_pkg::NUM_GPIO-1:0] cio_gpio_i,
  output logic [ao_periph_pkg::NUM_GPIO-1:0] cio_gpio_o,
  output logic [ao_periph_pkg::NUM_GPIO-1:0] cio_gpio_en_o,
  output logic [ao_periph_pkg::NUM_GPIO-1:0] intr_gpio_o
);
  import ao_periph_pkg::*;

  logic [NUM_GPIO-1:0] in_meta_q;
  logic [NUM_GPIO-1:0] in_sync_q;
  logic [NUM_GPIO-1:0] in_prev_q;
  logic [NUM_GPIO-1:0] out_q;
  logic [NUM_GPIO-1:0] oe_q;
  logic [NUM_GPIO-1:0] intr_en_q;
  logic [NUM_GPIO-1:0] status_q;
  logic [NUM_GPIO-1:0] rise;
  logic [NUM_GPIO-1:0] stat_clr;
  logic                wr_en;
  logic [4:0]          offset;

  assign offset   = {reg_req_i.addr[4:2], 2'b00};
  assign wr_en    = reg_req_i.valid && reg_req_i.write;
  assign rise     = in_sync_q & ~in_prev_q;
  assign stat_clr = (wr_en && offset == GPIO_INTR_STATUS) ? reg_req_i.wdata[NUM_GPIO-1:0] : '0;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      in_meta_q <= '0;
      in_sync_q <= '0;
      in_prev_q <= '0;
      out_q     <= '0;
      oe_q      <= '0;
      intr_en_q <= '0;
      status_q  <= '0;
    end else begin
      // Two-flop synchroniser, then edge history
      in_meta_q <= cio_gpio_i;
      in_sync_q <= in_meta_q;
      in_prev_q <= in_sync_q;
      status_q  <= (status_q & ~stat_clr) | (rise & intr_en_q);
      if (wr_en) begin
        case (offset)
          GPIO_OUT:     out_q     <= reg_req_i.wdata[NUM_GPIO-1:0];
          GPIO_OE:      oe_q      <= reg_req_i.wdata[NUM_GPIO-1:0];
          GPIO_INTR_EN: intr_en_q <= reg_req_i.wdata[NUM_GPIO-1:0];
          default: ;
        endcase
      end
    end
  end

  always_comb begin
    reg_rsp_o.ready = reg_req_i.valid;
    case (offset)
      GPIO_IN:          reg_rsp_o.rdata = 32'(in_sync_q);
      GPIO_OUT:         reg_rsp_o.rdata = 32'(out_q);
      GPIO_OE:          reg_rsp_o.rdata = 32'(oe_q);
      GPIO_INTR_EN:     reg_rsp_o.rdata = 32'(intr_en_q);
      GPIO_INTR_STATUS: reg_rsp_o.rdata = 32'(status_q);
      default:          reg_rsp_o.rdata = '0;
    endcase
  end

  assign cio_gpio_o    = out_q;
  assign cio_gpio_en_o = oe_q;
  assign intr_gpio_o   = status_q;

  // New status bits only on pins enabled the cycle before
  a_status_enabled : assert property (@(posedge clk_i) disable iff (reset_i)
    (status_q & ~$past(status_q) & ~$past(intr_en_q)) == '0);

endmodule

`default_nettype wire

// ==== src/ao_peripheral_subsystem.sv ====
// Always-on peripheral subsystem
// OBI bridge, address demux and the SoC control, fast interrupt and GPIO blocks

`timescale 1ns/100ps
`default_nettype none

module ao_peripheral_subsystem (
  input  logic                                    clk_i,
  input  logic                                    reset_i,

  input  ao_periph_pkg::obi_req_t                 slave_req_i,
  output ao_periph_pkg::obi_resp_t                slave_resp_o,

  // SoC control
  input  logic                                    boot_select_i,
  output logic                                    exit_valid_o,
  output logic [31:0]                             exit_value_o,

  // Fast interrupts
  input  logic [ao_periph_pkg::NUM_FAST_INTR-1:0] fast_intr_i,
  output logic [ao_periph_pkg::NUM_FAST_INTR-1:0] fast_intr_o,

  // GPIO pins
  input  logic [ao_periph_pkg::NUM_GPIO-1:0]      cio_gpio_i,
  output logic [ao_periph_pkg::NUM_GPIO-1:0]      cio_gpio_o,
  output logic [ao_periph_pkg::NUM_GPIO-1:0]      cio_gpio_en_o,
  output logic [ao_periph_pkg::NUM_GPIO-1:0]      intr_gpio_o
);
  import ao_periph_pkg::*;

  reg_req_t                  peripheral_req;
  reg_rsp_t                  peripheral_rsp;
  reg_req_t [NUM_PERIPH-1:0] ao_slv_req;
  reg_rsp_t [NUM_PERIPH-1:0] ao_slv_rsp;

  obi_to_reg obi_to_reg_i (
    .clk_i,
    .reset_i,
    .obi_req_i  (slave_req_i),
    .obi_resp_o (slave_resp_o),
    .reg_req_o  (peripheral_req),
    .reg_rsp_i  (peripheral_rsp)
  );

  reg_demux reg_demux_i (
    .reg_req_i    (peripheral_req),
    .reg_rsp_o    (peripheral_rsp),
    .periph_req_o (ao_slv_req),
    .periph_rsp_i (ao_slv_rsp),
    .clk_i,
    .reset_i
  );

  soc_ctrl soc_ctrl_i (
    .clk_i,
    .reset_i,
    .reg_req_i (ao_slv_req[SOC_CTRL_IDX]),
    .reg_rsp_o (ao_slv_rsp[SOC_CTRL_IDX]),
    .boot_select_i,
    .exit_valid_o,
    .exit_value_o
  );

  fast_intr_ctrl fast_intr_ctrl_i (
    .clk_i,
    .reset_i,
    .reg_req_i (ao_slv_req[FAST_INTR_IDX]),
    .reg_rsp_o (ao_slv_rsp[FAST_INTR_IDX]),
    .fast_intr_i,
    .fast_intr_o
  );

  gpio_ao gpio_ao_i (
    .clk_i,
    .reset_i,
    .reg_req_i (ao_slv_req[GPIO_IDX]),
    .reg_rsp_o (ao_slv_rsp[GPIO_IDX]),
    .cio_gpio_i,
    .cio_gpio_o,
    .cio_gpio_en_o,
    .intr_gpio_o
  );

endmodule

`default_nettype wire

// ==== tb/tb_ao_peripheral_subsystem.sv ====
// Testbench for the always-on peripheral subsystem
// Table of pin stimulus and bus accesses, checked against expected data and pins

`timescale 1ns/100ps
`default_nettype none

module tb_ao_peripheral_subsystem;
  import ao_periph_pkg::*;

  localparam logic [31:0] SOC_BASE      = 32'h0000_0000;
  localparam logic [31:0] FAST_BASE     = 32'h0000_1000;
  localparam logic [31:0] GPIO_BASE     = 32'h0000_2000;
  localparam logic [31:0] NONE_BASE     = 32'h0000_3000;
  localparam int          RESET_CYCLES  = 8;
  localparam int          SETTLE_CYCLES = 3;

  typedef struct packed {
    logic                     boot_sel;
    logic [NUM_FAST_INTR-1:0] fast_intr;
    logic [NUM_GPIO-1:0]      gpio_in;
    logic                     we;
    logic [31:0]              addr;
    logic [31:0]              wdata;
    logic [31:0]              exp_rdata;
    logic                     exp_valid;
    logic [31:0]              exp_value;
    logic [NUM_FAST_INTR-1:0] exp_fast;
    logic [NUM_GPIO-1:0]      exp_out;
    logic [NUM_GPIO-1:0]      exp_en;
    logic [NUM_GPIO-1:0]      exp_intr;
  } entry_t;

  logic                     clk = 1'b0;
  logic                     reset;
  obi_req_t                 slave_req;
  obi_resp_t                slave_resp;
  logic                     boot_select;
  logic                     exit_valid;
  logic [31:0]              exit_value;
  logic [NUM_FAST_INTR-1:0] fast_intr_in;
  logic [NUM_FAST_INTR-1:0] fast_intr_out;
  logic [NUM_GPIO-1:0]      gpio_in_pins;
  logic [NUM_GPIO-1:0]      gpio_out_pins;
  logic [NUM_GPIO-1:0]      gpio_en_pins;
  logic [NUM_GPIO-1:0]      gpio_intr;

  entry_t      table_q[$];
  string       name_q[$];
  entry_t      cur;
  logic [31:0] scratch;
  int          test_errs;
  int          fail_count;
  int          cycles = 0;
  int          max_cycles = 0;

  ao_peripheral_subsystem UUT (
    .clk_i         (clk),
    .reset_i       (reset),
    .slave_req_i   (slave_req),
    .slave_resp_o  (slave_resp),
    .boot_select_i (boot_select),
    .exit_valid_o  (exit_valid),
    .exit_value_o  (exit_value),
    .fast_intr_i   (fast_intr_in),
    .fast_intr_o   (fast_intr_out),
    .cio_gpio_i    (gpio_in_pins),
    .cio_gpio_o    (gpio_out_pins),
    .cio_gpio_en_o (gpio_en_pins),
    .intr_gpio_o   (gpio_intr)
  );

  always #10 clk = ~clk;

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles > max_cycles) begin
      $display("Timeout after %0d cycles, the DUT stopped answering the bus", cycles);
      $display("Test failed");
      $finish;
    end
  end

  function automatic logic [31:0] reg_addr(input logic [31:0] base, input logic [4:0] offset);
    return base | {27'b0, offset};
  endfunction

  task automatic check_value(input string test, input string what,
                             input logic [31:0] expected, input logic [31:0] actual);
    if (expected !== actual) begin
      $display("ERROR %s %s: expected %08h, actual %08h", test, what, expected, actual);
      test_errs++;
    end
  endtask

  // Pin state and expected outputs come from cur
  task automatic add_entry(input string name, input logic we, input logic [31:0] addr,
                           input logic [31:0] wdata, input logic [31:0] exp_rdata);
    entry_t e;
    e           = cur;
    e.we        = we;
    e.addr      = addr;
    e.wdata     = wdata;
    e.exp_rdata = exp_rdata;
    table_q.push_back(e);
    name_q.push_back(name);
  endtask

  task automatic build_table();
    cur          = '0;
    cur.boot_sel = 1'b1;
    add_entry("rst_exit_valid", 1'b0, reg_addr(SOC_BASE, SOC_CTRL_EXIT_VALID), '0, '0);
    add_entry("rst_exit_value", 1'b0, reg_addr(SOC_BASE, SOC_CTRL_EXIT_VALUE), '0, '0);
    add_entry("rst_boot_sel", 1'b0, reg_addr(SOC_BASE, SOC_CTRL_BOOT_SEL), '0, 32'h1);
    add_entry("rst_scratch", 1'b0, reg_addr(SOC_BASE, SOC_CTRL_SCRATCH), '0, '0);
    add_entry("rst_fast_pending", 1'b0, reg_addr(FAST_BASE, FAST_INTR_PENDING), '0, '0);
    add_entry("rst_fast_enable", 1'b0, reg_addr(FAST_BASE, FAST_INTR_ENABLE), '0, '0);
    add_entry("rst_gpio_in", 1'b0, reg_addr(GPIO_BASE, GPIO_IN), '0, '0);
    add_entry("rst_gpio_out", 1'b0, reg_addr(GPIO_BASE, GPIO_OUT), '0, '0);
    add_entry("rst_gpio_oe", 1'b0, reg_addr(GPIO_BASE, GPIO_OE), '0, '0);
    add_entry("rst_gpio_intr_en", 1'b0, reg_addr(GPIO_BASE, GPIO_INTR_EN), '0, '0);
    add_entry("rst_gpio_status", 1'b0, reg_addr(GPIO_BASE, GPIO_INTR_STATUS), '0, '0);
    cur.exp_value = 32'h0000_00A5;
    add_entry("wr_exit_value", 1'b1, reg_addr(SOC_BASE, SOC_CTRL_EXIT_VALUE), 32'hA5, '0);
    cur.exp_valid = 1'b1;
    add_entry("wr_exit_valid", 1'b1, reg_addr(SOC_BASE, SOC_CTRL_EXIT_VALID), 32'h1, '0);
    // Sticky flag ignores a zero write
    add_entry("wr_exit_valid_zero", 1'b1, reg_addr(SOC_BASE, SOC_CTRL_EXIT_VALID), '0, '0);
    add_entry("rd_exit_valid", 1'b0, reg_addr(SOC_BASE, SOC_CTRL_EXIT_VALID), '0, 32'h1);
    add_entry("wr_scratch", 1'b1, reg_addr(SOC_BASE, SOC_CTRL_SCRATCH), scratch, '0);
    add_entry("rd_scratch", 1'b0, reg_addr(SOC_BASE, SOC_CTRL_SCRATCH), '0, scratch);
    cur.exp_out = 8'h5A;
    add_entry("wr_gpio_out", 1'b1, reg_addr(GPIO_BASE, GPIO_OUT), 32'h5A, '0);
    cur.exp_en = 8'hF0;
    add_entry("wr_gpio_oe", 1'b1, reg_addr(GPIO_BASE, GPIO_OE), 32'hF0, '0);
    cur.gpio_in = 8'h3C;
    add_entry("rd_gpio_in", 1'b0, reg_addr(GPIO_BASE, GPIO_IN), '0, 32'h3C);
    add_entry("wr_gpio_intr_en", 1'b1, reg_addr(GPIO_BASE, GPIO_INTR_EN), 32'h01, '0);
    // Pins 0 and 7 rise, only pin 0 may flag
    cur.gpio_in  = 8'hBD;
    cur.exp_intr = 8'h01;
    add_entry("gpio_rise_status", 1'b0, reg_addr(GPIO_BASE, GPIO_INTR_STATUS), '0, 32'h01);
    cur.exp_intr = 8'h00;
    add_entry("wr_gpio_status_clr", 1'b1, reg_addr(GPIO_BASE, GPIO_INTR_STATUS), 32'hFF, '0);
    add_entry("rd_gpio_status", 1'b0, reg_addr(GPIO_BASE, GPIO_INTR_STATUS), '0, '0);
    add_entry("wr_fast_enable", 1'b1, reg_addr(FAST_BASE, FAST_INTR_ENABLE), 32'h5, '0);
    cur.fast_intr = 15'h0007;
    cur.exp_fast  = 15'h0005;
    add_entry("fast_pending", 1'b0, reg_addr(FAST_BASE, FAST_INTR_PENDING), '0, 32'h7);
    cur.fast_intr = '0;
    cur.exp_fast  = 15'h0004;
    add_entry("wr_fast_clr", 1'b1, reg_addr(FAST_BASE, FAST_INTR_PENDING), 32'h3, '0);
    add_entry("rd_fast_pending", 1'b0, reg_addr(FAST_BASE, FAST_INTR_PENDING), '0, 32'h4);
    add_entry("wr_unmapped", 1'b1, reg_addr(NONE_BASE, SOC_CTRL_SCRATCH), 32'hFFFF_FFFF, '0);
    add_entry("rd_unmapped", 1'b0, reg_addr(NONE_BASE, SOC_CTRL_SCRATCH), '0, '0);
    add_entry("rd_scratch_after", 1'b0, reg_addr(SOC_BASE, SOC_CTRL_SCRATCH), '0, scratch);
    add_entry("rd_exit_value", 1'b0, reg_addr(SOC_BASE, SOC_CTRL_EXIT_VALUE), '0, 32'hA5);
  endtask

  // Pins settle past the synchroniser and edge register before the access
  task automatic apply_pins(input entry_t e);
    @(posedge clk);
    boot_select  <= e.boot_sel;
    fast_intr_in <= e.fast_intr;
    gpio_in_pins <= e.gpio_in;
    repeat (SETTLE_CYCLES) @(posedge clk);
  endtask

  task automatic bus_access(input string test, input entry_t e, output logic [31:0] rdata);
    int lat;
    @(posedge clk);
    slave_req.req   <= 1'b1;
    slave_req.we    <= e.we;
    slave_req.addr  <= e.addr;
    slave_req.wdata <= e.wdata;
    @(negedge clk);
    while (!slave_resp.gnt) begin
      @(negedge clk);
    end
    @(posedge clk);
    slave_req.req <= 1'b0;
    lat = 1;
    @(negedge clk);
    while (!slave_resp.rvalid && lat < 4) begin
      @(negedge clk);
      lat++;
    end
    if (lat != 2 || !slave_resp.rvalid) begin
      $display("%s: rvalid did not arrive exactly 2 cycles after gnt", test);
      test_errs++;
    end
    rdata = slave_resp.rdata;
  endtask

  initial begin
    entry_t      e;
    logic [31:0] rdata;
    slave_req    = '0;
    boot_select  = 1'b0;
    fast_intr_in = '0;
    gpio_in_pins = '0;
    reset        = 1'b1;
    fail_count   = 0;
    void'($urandom(51));
    scratch = $urandom();
    build_table();
    max_cycles = RESET_CYCLES + 12 * table_q.size() + 20;
    repeat (RESET_CYCLES) @(posedge clk);
    reset <= 1'b0;
    foreach (table_q[i]) begin
      e         = table_q[i];
      test_errs = 0;
      apply_pins(e);
      bus_access(name_q[i], e, rdata);
      check_value(name_q[i], "rdata", e.exp_rdata, rdata);
      check_value(name_q[i], "exit_valid_o", 32'(e.exp_valid), 32'(exit_valid));
      check_value(name_q[i], "exit_value_o", e.exp_value, exit_value);
      check_value(name_q[i], "fast_intr_o", 32'(e.exp_fast), 32'(fast_intr_out));
      check_value(name_q[i], "cio_gpio_o", 32'(e.exp_out), 32'(gpio_out_pins));
      check_value(name_q[i], "cio_gpio_en_o", 32'(e.exp_en), 32'(gpio_en_pins));
      check_value(name_q[i], "intr_gpio_o", 32'(e.exp_intr), 32'(gpio_intr));
      if (test_errs == 0) begin
        $display("PASS %s", name_q[i]);
      end else begin
        $display("FAIL %s", name_q[i]);
        fail_count++;
      end
    end
    $display("%0d tests, %0d passed, %0d failed",
             table_q.size(), table_q.size() - fail_count, fail_count);
    if (fail_count == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== vlog.f ====
src/ao_periph_pkg.sv
src/obi_to_reg.sv
src/reg_demux.sv
src/soc_ctrl.sv
src/fast_intr_ctrl.sv
src/gpio_ao.sv
src/ao_peripheral_subsystem.sv
tb/tb_ao_peripheral_subsystem.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       := tb_ao_peripheral_subsystem
FILELIST  := vlog.f
OBJ_DIR   := obj_dir
PASS_MSG  := Test completed successfully

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
